/* cancid.f */
hdl/cancid_pkg.sv
hdl/keyword_dfa.sv
hdl/stream_state_store.sv
hdl/stream_enable_table.sv
hdl/category_counter.sv
hdl/cancid_top.sv
sim/cancid_tb.sv

/* hdl/cancid_pkg.sv */
`default_nettype none

package cancid_pkg;

   // Stream identifier space
   localparam int STREAM_W    = 6;
   localparam int NUM_STREAMS = 64;

   // Fixed keyword, first character in the top byte
   localparam int          KW_LEN  = 4;
   localparam logic [31:0] KEYWORD = {8'h73, 8'h76, 8'h6e, 8'h3a};

   // Enough bits to count from 0 up to KW_LEN
   localparam int PROGRESS_W = 3;

   // Category count width, wraps on overflow
   localparam int COUNT_W = 16;

   // Automaton state as saved per stream
   typedef struct packed {
      logic [PROGRESS_W-1:0] progress;
   } dfa_state_t;

   // Per-packet control strobes
   typedef struct packed {
      logic                load_state;
      logic                new_stream;
      logic                eop;
      logic [STREAM_W-1:0] stream_id;
   } pkt_ctrl_t;

   // One character per beat
   typedef struct packed {
      logic       char_vld;
      logic [7:0] char;
   } char_beat_t;

   // Write to the per-stream enable table
   typedef struct packed {
      logic                wr;
      logic [STREAM_W-1:0] stream_id;
      logic                enable;
   } cfg_wr_t;

endpackage

`default_nettype wire

/* hdl/cancid_top.sv */
`default_nettype none

module cancid_top
   import cancid_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  pkt_ctrl_t          ctrl,
   input  char_beat_t         beat,
   input  cfg_wr_t            cfg,
   output logic [COUNT_W-1:0] count,
   output logic               fired
);

   // Category enable for the stream on ctrl
   logic enable;

   // Per-stream enable bits, written from the configuration port
   stream_enable_table stream_enable_table_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg       (cfg),
      .stream_id (ctrl.stream_id),
      .enable    (enable)
   );

   // Matcher, state store and count for the one category
   category_counter category_counter_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .ctrl   (ctrl),
      .beat   (beat),
      .enable (enable),
      .count  (count),
      .fired  (fired)
   );

endmodule

`default_nettype wire

/* hdl/category_counter.sv */
`default_nettype none

module category_counter
   import cancid_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  pkt_ctrl_t          ctrl,
   input  char_beat_t         beat,
   input  logic               enable,
   output logic [COUNT_W-1:0] count,
   output logic               fired
);

   logic               restore_vld;
   dfa_state_t         restore_state;
   dfa_state_t         state_out;
   logic               accept;

   // Speculative hit for the current packet
   logic               fired_q;
   logic [COUNT_W-1:0] count_q;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         fired_q <= 1'b0;
         count_q <= '0;
      end
      else
      begin
         // New packet drops the previous flag
         if (ctrl.load_state)
         begin
            fired_q <= 1'b0;
         end

         // End of packet, fold in or discard
         if (ctrl.eop)
         begin
            if (enable)
            begin
               count_q <= count_q + COUNT_W'(fired_q);
            end
            else
            begin
               fired_q <= 1'b0;
            end
         end

         // Keyword hit wins over a clear
         if (accept)
         begin
            fired_q <= 1'b1;
         end
      end
   end

   stream_state_store stream_state_store_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .ctrl          (ctrl),
      .enable        (enable),
      .save_state    (state_out),
      .restore_vld   (restore_vld),
      .restore_state (restore_state)
   );

   keyword_dfa keyword_dfa_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .restore_vld   (restore_vld),
      .restore_state (restore_state),
      .beat          (beat),
      .state_out     (state_out),
      .accept        (accept)
   );

   assign fired = fired_q;
   assign count = count_q;

endmodule

`default_nettype wire

/* hdl/keyword_dfa.sv */
`default_nettype none

module keyword_dfa
   import cancid_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       restore_vld,
   input  dfa_state_t restore_state,
   input  char_beat_t beat,
   output dfa_state_t state_out,
   output logic       accept
);

   dfa_state_t            state_q;
   logic                  accept_q;
   logic [PROGRESS_W-1:0] base_progress;
   logic [PROGRESS_W-1:0] next_progress;

   // Keyword character at a given position, position 0 is the first one
   function automatic logic [7:0] kw_char(input logic [PROGRESS_W-1:0] idx);
      kw_char = KEYWORD[(KW_LEN - 1 - idx) * 8 +: 8];
   endfunction

   // Next progress from current progress and the incoming character
   always_comb
   begin
      // A completed match restarts from the empty prefix
      if (state_q.progress == PROGRESS_W'(KW_LEN))
      begin
         base_progress = '0;
      end
      else
      begin
         base_progress = state_q.progress;
      end

      if (beat.char == kw_char(base_progress))
      begin
         next_progress = base_progress + PROGRESS_W'(1);
      end
      // Mismatch, but this character may start a new keyword
      else if (beat.char == kw_char('0))
      begin
         next_progress = PROGRESS_W'(1);
      end
      else
      begin
         next_progress = '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q  <= '0;
         accept_q <= 1'b0;
      end
      // Restore from the state store has priority over a character
      else if (restore_vld)
      begin
         state_q  <= restore_state;
         accept_q <= 1'b0;
      end
      else if (beat.char_vld)
      begin
         state_q.progress <= next_progress;
         // Single pulse on keyword completion
         accept_q         <= (next_progress == PROGRESS_W'(KW_LEN));
      end
      else
      begin
         accept_q <= 1'b0;
      end
   end

   assign state_out = state_q;
   assign accept    = accept_q;

endmodule

`default_nettype wire

/* hdl/stream_enable_table.sv */
`default_nettype none

module stream_enable_table
   import cancid_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  cfg_wr_t             cfg,
   input  logic [STREAM_W-1:0] stream_id,
   output logic                enable
);

   // One category enable bit per stream
   logic [NUM_STREAMS-1:0] enable_q;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         // All streams start disabled
         enable_q <= '0;
      end
      else if (cfg.wr)
      begin
         enable_q[cfg.stream_id] <= cfg.enable;
      end
   end

   // Current stream's bit, read without delay
   assign enable = enable_q[stream_id];

endmodule

`default_nettype wire

/* hdl/stream_state_store.sv */
`default_nettype none

module stream_state_store
   import cancid_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  pkt_ctrl_t  ctrl,
   input  logic       enable,
   input  dfa_state_t save_state,
   output logic       restore_vld,
   output dfa_state_t restore_state
);

   // One saved automaton state per stream
   dfa_state_t state_mem [NUM_STREAMS];

   logic       restore_vld_q;
   dfa_state_t restore_state_q;

   // Restore strobe, one cycle after packet start
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         restore_vld_q <= 1'b0;
      end
      else
      begin
         restore_vld_q <= ctrl.load_state;
      end
   end

   // Restore state, zero for a stream without history
   always_ff @(posedge clk)
   begin
      if (ctrl.load_state)
      begin
         if (ctrl.new_stream)
         begin
            restore_state_q <= '0;
         end
         else
         begin
            restore_state_q <= state_mem[ctrl.stream_id];
         end
      end
   end

   // Save at end of packet, only for an enabled stream
   always_ff @(posedge clk)
   begin
      if (ctrl.eop && enable)
      begin
         state_mem[ctrl.stream_id] <= save_state;
      end
   end

   assign restore_vld   = restore_vld_q;
   assign restore_state = restore_state_q;

endmodule

`default_nettype wire

/* sim/cancid_tb.sv */
`default_nettype none

module cancid_tb
   import cancid_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   logic               clk = 1'b0;
   logic               rst_n;
   pkt_ctrl_t          ctrl;
   char_beat_t         beat;
   cfg_wr_t            cfg;
   logic [COUNT_W-1:0] count;
   logic               fired;

   // Data file lines, comments and blank lines removed
   string data_lines[$];

   int cycle_cnt   = 0;
   int cycle_limit = 100;
   int error_cnt   = 0;
   int pass_cnt    = 0;
   int fail_cnt    = 0;

   cancid_top cancid_top_i (
      .clk   (clk),
      .rst_n (rst_n),
      .ctrl  (ctrl),
      .beat  (beat),
      .cfg   (cfg),
      .count (count),
      .fired (fired)
   );

   // 100 ns clock period
   always #50 clk = ~clk;

   // Watchdog, limit set once the data file is known
   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt >= cycle_limit)
      begin
         $display("Simulation timed out after %0d cycles", cycle_cnt);
         $display("Test FAILED");
         $finish;
      end
   end

   // Next rising edge, then the drive offset
   task automatic next_cycle();
      @(posedge clk);
      #5;
   endtask

   task automatic check_fired(input logic expected, input logic observed, input string what);
      if (observed !== expected)
      begin
         $display("FAILED at %0t: %s fired expected %0b, got %0b",
                  $time, what, expected, observed);
         error_cnt++;
      end
   endtask

   task automatic check_count(input logic [COUNT_W-1:0] expected,
                              input logic [COUNT_W-1:0] observed, input string what);
      if (observed !== expected)
      begin
         $display("FAILED at %0t: %s count expected %0d, got %0d",
                  $time, what, expected, observed);
         error_cnt++;
      end
   endtask

   // Single-cycle write into the enable table
   task automatic write_enable(input int stream, input int en);
      cfg.wr        = 1'b1;
      cfg.stream_id = STREAM_W'(stream);
      cfg.enable    = (en != 0);
      next_cycle();
      cfg = '0;
   endtask

   // One packet in the order load, idle, characters, idle, eop
   task automatic send_packet(input int stream, input int is_new, input string chars,
                              input int exp_fired, input int exp_count, input string what);
      logic               seen_fired;
      logic [COUNT_W-1:0] seen_count;
      int                 errors_before;
      errors_before   = error_cnt;
      ctrl.stream_id  = STREAM_W'(stream);
      ctrl.load_state = 1'b1;
      ctrl.new_stream = (is_new != 0);
      next_cycle();
      // Restore lands during this idle cycle
      ctrl.load_state = 1'b0;
      ctrl.new_stream = 1'b0;
      next_cycle();
      for (int i = 0; i < chars.len(); i++)
      begin
         beat.char_vld = 1'b1;
         beat.char     = chars.getc(i);
         next_cycle();
      end
      beat = '0;
      next_cycle();
      // Hit flag has settled before eop
      seen_fired = fired;
      ctrl.eop   = 1'b1;
      next_cycle();
      ctrl.eop   = 1'b0;
      seen_count = count;
      check_fired(exp_fired != 0, seen_fired, what);
      check_count(COUNT_W'(exp_count), seen_count, what);
      if (error_cnt == errors_before)
      begin
         pass_cnt++;
         $display("%s: passed", what);
      end
      else
      begin
         fail_cnt++;
         $display("%s: failed", what);
      end
   endtask

   initial
   begin
      int    fd;
      int    code;
      int    fields;
      int    stream;
      int    is_new;
      int    en;
      int    exp_fired;
      int    exp_count;
      int    test_no;
      string line;
      string kind;
      string chars;

      rst_n   = 1'b0;
      ctrl    = '0;
      beat    = '0;
      cfg     = '0;
      test_no = 0;

      fd = $fopen("sim/cancid_testdata.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the test data file");
         $display("Test FAILED");
         $finish;
      end
      else
      begin
         while (!$feof(fd))
         begin
            code = $fgets(line, fd);
            // Skip comments and empty lines
            if (code > 1 && line.getc(0) != "#")
            begin
               data_lines.push_back(line);
            end
         end
         $fclose(fd);
         cycle_limit = 40 * data_lines.size() + 100;

         // Reset held for 8 cycles
         repeat (8) @(posedge clk);
         #5;
         rst_n = 1'b1;
         next_cycle();

         foreach (data_lines[i])
         begin
            kind = "";
            if (data_lines[i].getc(0) == "C")
            begin
               fields = $sscanf(data_lines[i], "%s %d %d", kind, stream, en);
               if (fields != 3)
               begin
                  $display("Malformed configuration line: %s", data_lines[i]);
                  error_cnt++;
               end
               else
               begin
                  write_enable(stream, en);
               end
            end
            else if (data_lines[i].getc(0) == "P")
            begin
               fields = $sscanf(data_lines[i], "%s %d %d %s %d %d",
                                kind, stream, is_new, chars, exp_fired, exp_count);
               test_no++;
               if (fields != 6)
               begin
                  $display("Malformed packet line: %s", data_lines[i]);
                  error_cnt++;
                  fail_cnt++;
               end
               else
               begin
                  send_packet(stream, is_new, chars, exp_fired, exp_count,
                              $sformatf("Packet %0d stream %0d \"%s\"", test_no, stream, chars));
               end
            end
            else
            begin
               $display("Unknown line in test data: %s", data_lines[i]);
               error_cnt++;
            end
         end

         if (pass_cnt + fail_cnt == 0)
         begin
            $display("No packet tests found in the data file");
            error_cnt++;
         end

         $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
         if (error_cnt == 0 && fail_cnt == 0)
         begin
            $display("Test OK");
         end
         else
         begin
            $display("Test FAILED");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

/* sim/cancid_testdata.txt */
# C <stream> <enable>   : configuration write to the enable table
# P <stream> <new> <chars> <fired> <count> : packet, expected flag and running count
C 1 1
C 2 1
C 3 1
C 5 1
# Keyword inside one packet, then a packet without it
P 1 1 xxsvn:yy 1 1
P 1 1 hello 0 1
# Keyword split over two packets of stream 2
P 2 1 xsv 0 1
P 2 0 n:z 1 2
# Same split, second packet starts fresh
P 2 1 xsv 0 2
P 2 1 n:z 0 2
# Interleaved streams 3 and 5 keep their own progress
P 3 1 sv 0 2
P 5 1 n: 0 2
P 3 0 n: 1 3
P 5 0 qq 0 3
# Stream 7 gets a known saved state, then is disabled
C 7 1
P 7 1 ab 0 3
C 7 0
P 7 1 svn: 1 3
P 7 0 sv 0 3
P 7 0 n: 0 3
# Re-enabled, two matches add one
C 7 1
P 7 0 svn:svn: 1 4
# Disable and re-enable stream 1
C 1 0
P 1 1 svn: 1 4
C 1 1
P 1 0 svsvn: 1 5
# Saved complete match restarts from the empty prefix
P 1 0 vn: 0 5
P 3 0 svn:svn:svn: 1 6
P 5 0 svn 0 6
P 5 0 : 1 7
P 2 0 svnsvn: 1 8
P 3 1 zzzz 0 8
